//--- hw/usb_in_pkg.sv
package usb_in_pkg;

  // Endpoint number width, up to four IN endpoints
  localparam int EP_BITS = 2;

  // Packet size width, enough for 512 byte HS bulk packets
  localparam int SIZE_BITS = 10;

  // One byte from the local data source
  typedef struct packed {
    logic               tlast;
    logic [EP_BITS-1:0] tdest;
    logic [7:0]         tdata;
  } src_beat_t;

  // One byte towards the USB controller
  typedef struct packed {
    logic       tlast;
    // DATA0/DATA1 toggle of the owning endpoint
    logic       data1;
    logic [7:0] tdata;
  } tx_beat_t;

  // IN token from the USB controller
  typedef struct packed {
    logic [EP_BITS-1:0] ep;
  } token_t;

  // Host handshake result, single-cycle pulses
  typedef struct packed {
    logic ack;
    logic timedout;
  } hs_t;

  // Control pipe requests plus packet size limit
  typedef struct packed {
    logic                 set_conf;
    logic                 clr_conf;
    logic [SIZE_BITS-1:0] max_size;
  } ep_conf_t;

endpackage

//--- hw/ep_dispatch.sv
`timescale 1ns/1ps

module ep_dispatch #(
  parameter int NUM_EP = 4
) (
  input  logic                  clock,
  input  logic                  reset_i,
  input  logic                  src_valid_i,
  input  usb_in_pkg::src_beat_t src_beat_i,
  input  logic [NUM_EP-1:0]     wr_ready_i,
  output logic                  src_ready_o,
  output logic [NUM_EP-1:0]     wr_valid_o,
  output usb_in_pkg::src_beat_t wr_beat_o
);

  // Destination locked for the rest of the packet
  logic [usb_in_pkg::EP_BITS-1:0] dest_q;
  // High between first beat and tlast beat
  logic                           in_pkt_q;
  logic [usb_in_pkg::EP_BITS-1:0] cur_dest;
  logic                           xfer;

  // First beat picks tdest, later beats follow the latch
  assign cur_dest = in_pkt_q ? dest_q : src_beat_i.tdest;

  // Only the chosen buffer sees valid
  always_comb begin
    wr_valid_o = '0;
    for (int i = 0; i < NUM_EP; i++) begin
      if (int'(cur_dest) == i) begin
        wr_valid_o[i] = src_valid_i;
      end
    end
  end

  // Ready comes back from that buffer alone
  // an out-of-range endpoint never gets ready
  always_comb begin
    src_ready_o = 1'b0;
    for (int i = 0; i < NUM_EP; i++) begin
      if (int'(cur_dest) == i) begin
        src_ready_o = wr_ready_i[i];
      end
    end
  end

  assign xfer = src_valid_i && src_ready_o;

  // Payload goes to every buffer, tdest rewritten to the locked value
  assign wr_beat_o.tlast = src_beat_i.tlast;
  assign wr_beat_o.tdest = cur_dest;
  assign wr_beat_o.tdata = src_beat_i.tdata;

  // Packet tracking
  always_ff @(posedge clock) begin
    if (reset_i) begin
      in_pkt_q <= 1'b0;
      dest_q   <= '0;
    end else if (xfer) begin
      // tlast closes the packet and frees the lock
      in_pkt_q <= !src_beat_i.tlast;
      dest_q   <= cur_dest;
    end
  end

  // Source must address an existing endpoint
  a_dest_range: assert property (@(posedge clock) disable iff (reset_i)
    src_valid_i |-> (int'(src_beat_i.tdest) < NUM_EP));

  // No endpoint switch in the middle of a packet
  a_dest_stable: assert property (@(posedge clock) disable iff (reset_i)
    (in_pkt_q && src_valid_i) |-> (src_beat_i.tdest == dest_q));

endmodule

//--- hw/ep_in_buffer.sv
`timescale 1ns/1ps

module ep_in_buffer #(
  parameter int DEPTH = 64
) (
  input  logic                  clock,
  input  logic                  reset_i,
  input  usb_in_pkg::ep_conf_t  conf_i,
  input  logic                  wr_valid_i,
  input  usb_in_pkg::src_beat_t wr_beat_i,
  input  logic                  rd_ready_i,
  input  usb_in_pkg::hs_t       hs_i,
  output logic                  wr_ready_o,
  output logic                  pkt_ready_o,
  output logic                  rd_valid_o,
  output usb_in_pkg::tx_beat_t  rd_beat_o
);

  localparam int ABITS = $clog2(DEPTH);

  // Ring storage, data plus end-of-packet flag
  logic [7:0] mem_data [DEPTH];
  logic       mem_last [DEPTH];

  // Pointers carry one extra wrap bit
  logic [ABITS:0] wr_ptr_q;
  // End of the last closed packet
  logic [ABITS:0] cmt_ptr_q;
  logic [ABITS:0] rd_ptr_q;
  // Start of the oldest unreleased packet
  logic [ABITS:0] start_ptr_q;
  logic [ABITS:0] fill;
  logic           full;

  // Bytes so far in the open packet
  logic [usb_in_pkg::SIZE_BITS-1:0] cnt_q;
  logic [usb_in_pkg::SIZE_BITS-1:0] cnt_next;

  logic clear_q;
  logic en_q;
  logic toggle_q;
  // Packet being sent, waiting for ACK or timeout
  logic in_flight_q;
  // Flagged byte already fetched
  logic sent_last_q;
  logic out_valid_q;
  logic out_last_q;
  logic [7:0] out_data_q;

  logic wr_en;
  logic close;
  logic more;
  logic fetch;
  logic hs_any;

  assign fill = wr_ptr_q - start_ptr_q;
  assign full = fill[ABITS];

  assign wr_ready_o = en_q && !full && !clear_q;
  assign wr_en      = wr_valid_i && wr_ready_o;

  // Packet ends on tlast or at max_size bytes
  assign cnt_next = cnt_q + 1'b1;
  assign close    = wr_beat_i.tlast || (cnt_next == conf_i.max_size);

  // Keep fetching until the flagged byte has left the ring
  assign more   = !sent_last_q && (rd_ptr_q != cmt_ptr_q);
  assign fetch  = rd_ready_i && more;
  assign hs_any = hs_i.ack || hs_i.timedout;

  // One-cycle clear from reset or the control pipe
  always_ff @(posedge clock) begin
    clear_q <= reset_i || conf_i.set_conf || conf_i.clr_conf;
  end

  // Endpoint enable
  always_ff @(posedge clock) begin
    if (reset_i || conf_i.clr_conf) begin
      en_q <= 1'b0;
    end else if (conf_i.set_conf) begin
      en_q <= 1'b1;
    end
  end

  // Ring write, data and flag
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem_data[wr_ptr_q[ABITS-1:0]] <= wr_beat_i.tdata;
      mem_last[wr_ptr_q[ABITS-1:0]] <= close;
    end
  end

  // Write side pointers and packet splitting
  always_ff @(posedge clock) begin
    if (reset_i || clear_q) begin
      wr_ptr_q  <= '0;
      cmt_ptr_q <= '0;
      cnt_q     <= '0;
    end else if (wr_en) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      if (close) begin
        // Packet becomes visible to the reader
        cmt_ptr_q <= wr_ptr_q + 1'b1;
        cnt_q     <= '0;
      end else begin
        cnt_q <= cnt_next;
      end
    end
  end

  // Read side, handshakes and toggle
  always_ff @(posedge clock) begin
    if (reset_i || clear_q) begin
      rd_ptr_q    <= '0;
      start_ptr_q <= '0;
      toggle_q    <= 1'b0;
      in_flight_q <= 1'b0;
      sent_last_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (hs_any) begin
      in_flight_q <= 1'b0;
      sent_last_q <= 1'b0;
      if (hs_i.ack) begin
        // Release the packet, next one uses the other PID
        start_ptr_q <= rd_ptr_q;
        toggle_q    <= !toggle_q;
      end else begin
        // Rewind for a resend with the same PID
        rd_ptr_q <= start_ptr_q;
      end
    end else if (fetch) begin
      rd_ptr_q    <= rd_ptr_q + 1'b1;
      in_flight_q <= 1'b1;
      out_valid_q <= 1'b1;
      if (mem_last[rd_ptr_q[ABITS-1:0]]) begin
        sent_last_q <= 1'b1;
      end
    end else if (rd_ready_i) begin
      // Output taken, nothing left to load
      out_valid_q <= 1'b0;
    end
  end

  // Registered ring read
  always_ff @(posedge clock) begin
    if (fetch) begin
      out_data_q <= mem_data[rd_ptr_q[ABITS-1:0]];
      out_last_q <= mem_last[rd_ptr_q[ABITS-1:0]];
    end
  end

  // Closed packet held and nothing in flight
  always_ff @(posedge clock) begin
    if (reset_i || clear_q) begin
      pkt_ready_o <= 1'b0;
    end else begin
      pkt_ready_o <= (cmt_ptr_q != start_ptr_q) && !in_flight_q && !hs_any;
    end
  end

  assign rd_valid_o      = out_valid_q;
  assign rd_beat_o.tlast = out_last_q;
  assign rd_beat_o.data1 = toggle_q;
  assign rd_beat_o.tdata = out_data_q;

  // Arbiter only routes a handshake after this buffer streamed
  a_hs_in_flight: assert property (@(posedge clock) disable iff (reset_i || clear_q)
    hs_any |-> in_flight_q);

  // Read stays behind commit, commit behind write, and the ring never overfills
  a_no_overflow: assert property (@(posedge clock) disable iff (reset_i || clear_q)
    ((rd_ptr_q - start_ptr_q) <= (cmt_ptr_q - start_ptr_q)) &&
    ((cmt_ptr_q - start_ptr_q) <= fill) && (fill <= DEPTH));

endmodule

//--- hw/ep_tx_arbiter.sv
`timescale 1ns/1ps

module ep_tx_arbiter #(
  parameter int NUM_EP = 4
) (
  input  logic                 clock,
  input  logic                 reset_i,
  input  logic                 token_valid_i,
  input  usb_in_pkg::token_t   token_i,
  input  usb_in_pkg::hs_t      hs_i,
  input  logic                 usb_ready_i,
  input  logic [NUM_EP-1:0]    pkt_ready_i,
  input  logic [NUM_EP-1:0]    rd_valid_i,
  input  usb_in_pkg::tx_beat_t rd_beat_i [NUM_EP],
  output logic [NUM_EP-1:0]    rd_ready_o,
  output usb_in_pkg::hs_t      hs_o [NUM_EP],
  output logic                 usb_valid_o,
  output usb_in_pkg::tx_beat_t usb_beat_o,
  output logic                 nak_o,
  output logic                 busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_WAIT
  } state_t;

  state_t state_q;

  // Token captured while idle, decided next cycle
  logic               tok_pend_q;
  usb_in_pkg::token_t tok_q;
  usb_in_pkg::token_t grant_q;
  logic               pkt_ok;
  logic               hs_any;
  logic               last_xfer;

  // Endpoint must exist and hold a closed packet
  assign pkt_ok = (int'(tok_q.ep) < NUM_EP) && pkt_ready_i[tok_q.ep];
  assign hs_any = hs_i.ack || hs_i.timedout;

  // Granted stream goes straight to the USB port
  assign usb_valid_o = (state_q == ST_STREAM) && rd_valid_i[grant_q.ep];
  assign usb_beat_o  = rd_beat_i[grant_q.ep];
  assign last_xfer   = usb_valid_o && usb_ready_i && usb_beat_o.tlast;

  assign busy_o = (state_q != ST_IDLE);

  // Ready to the granted buffer only
  // an empty output register may always load
  always_comb begin
    for (int i = 0; i < NUM_EP; i++) begin
      rd_ready_o[i] = (state_q == ST_STREAM) && (int'(grant_q.ep) == i) &&
                      (usb_ready_i || !rd_valid_i[i]);
      hs_o[i] = '0;
      if ((state_q == ST_WAIT) && (int'(grant_q.ep) == i)) begin
        hs_o[i] = hs_i;
      end
    end
  end

  // Token capture
  always_ff @(posedge clock) begin
    if (reset_i) begin
      tok_pend_q <= 1'b0;
    end else begin
      tok_pend_q <= token_valid_i && (state_q == ST_IDLE) && !tok_pend_q;
    end
  end

  always_ff @(posedge clock) begin
    if (token_valid_i) begin
      tok_q <= token_i;
    end
  end

  // Transaction FSM plus NAK pulse
  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      grant_q <= '0;
      nak_o   <= 1'b0;
    end else begin
      nak_o <= 1'b0;
      unique case (state_q)
        ST_IDLE: begin
          if (tok_pend_q && pkt_ok) begin
            state_q <= ST_STREAM;
            grant_q <= tok_q;
          end else if (tok_pend_q) begin
            nak_o <= 1'b1;
          end
        end
        ST_STREAM: begin
          // Last byte out, now the host answers
          if (last_xfer) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (hs_any) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Host handshakes only follow a finished packet
  a_hs_in_wait: assert property (@(posedge clock) disable iff (reset_i)
    hs_any |-> (state_q == ST_WAIT));

endmodule

//--- hw/usb_bulk_in.sv
`timescale 1ns/1ps

module usb_bulk_in #(
  parameter int NUM_EP = 4,
  parameter int DEPTH  = 64
) (
  input  logic                  clock,
  input  logic                  reset_i,
  input  usb_in_pkg::ep_conf_t  conf_i,
  input  logic                  src_valid_i,
  input  usb_in_pkg::src_beat_t src_beat_i,
  input  logic                  token_valid_i,
  input  usb_in_pkg::token_t    token_i,
  input  usb_in_pkg::hs_t       hs_i,
  input  logic                  usb_ready_i,
  output logic                  src_ready_o,
  output logic                  usb_valid_o,
  output usb_in_pkg::tx_beat_t  usb_beat_o,
  output logic                  nak_o,
  output logic                  busy_o,
  output logic [NUM_EP-1:0]     ep_ready_o
);

  // Dispatcher to buffers
  logic [NUM_EP-1:0]     wr_valid;
  logic [NUM_EP-1:0]     wr_ready;
  usb_in_pkg::src_beat_t wr_beat;

  // Buffers to arbiter
  logic [NUM_EP-1:0]     rd_valid;
  logic [NUM_EP-1:0]     rd_ready;
  usb_in_pkg::tx_beat_t  rd_beat [NUM_EP];
  usb_in_pkg::hs_t       ep_hs [NUM_EP];

  ep_dispatch #(
    .NUM_EP(NUM_EP)
  ) u_dispatch (
    .clock      (clock),
    .reset_i    (reset_i),
    .src_valid_i(src_valid_i),
    .src_beat_i (src_beat_i),
    .wr_ready_i (wr_ready),
    .src_ready_o(src_ready_o),
    .wr_valid_o (wr_valid),
    .wr_beat_o  (wr_beat)
  );

  // One ring per IN endpoint, ep_ready_o straight from pkt_ready
  for (genvar g = 0; g < NUM_EP; g++) begin : g_ep
    ep_in_buffer #(
      .DEPTH(DEPTH)
    ) u_buf (
      .clock      (clock),
      .reset_i    (reset_i),
      .conf_i     (conf_i),
      .wr_valid_i (wr_valid[g]),
      .wr_beat_i  (wr_beat),
      .rd_ready_i (rd_ready[g]),
      .hs_i       (ep_hs[g]),
      .wr_ready_o (wr_ready[g]),
      .pkt_ready_o(ep_ready_o[g]),
      .rd_valid_o (rd_valid[g]),
      .rd_beat_o  (rd_beat[g])
    );
  end

  ep_tx_arbiter #(
    .NUM_EP(NUM_EP)
  ) u_arbiter (
    .clock        (clock),
    .reset_i      (reset_i),
    .token_valid_i(token_valid_i),
    .token_i      (token_i),
    .hs_i         (hs_i),
    .usb_ready_i  (usb_ready_i),
    .pkt_ready_i  (ep_ready_o),
    .rd_valid_i   (rd_valid),
    .rd_beat_i    (rd_beat),
    .rd_ready_o   (rd_ready),
    .hs_o         (ep_hs),
    .usb_valid_o  (usb_valid_o),
    .usb_beat_o   (usb_beat_o),
    .nak_o        (nak_o),
    .busy_o       (busy_o)
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clock_o,
  output logic reset_o
);

  // Free running clock, low at time zero
  initial begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2) clock_o = ~clock_o;
  end

  // Reset held over the first rising edges, dropped on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

//--- tests/tb_usb_bulk_in.sv
`timescale 1ns/1ps

module tb_usb_bulk_in;

  localparam int NUM_EP = 4;
  localparam int DEPTH  = 64;
  localparam int SEED   = 32'h0f4b_7ab5;

  // Bytes moved per test, replayed bytes counted twice
  localparam int TOTAL_BYTES = 10 + 20 + 14 + 27 + 18;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 4 + 2000;

  logic                  clock;
  logic                  reset;
  usb_in_pkg::ep_conf_t  conf;
  logic                  src_valid;
  usb_in_pkg::src_beat_t src_beat;
  logic                  token_valid;
  usb_in_pkg::token_t    token;
  usb_in_pkg::hs_t       hs;
  logic                  usb_ready;
  logic                  src_ready;
  logic                  usb_valid;
  usb_in_pkg::tx_beat_t  usb_beat;
  logic                  nak;
  logic                  busy;
  logic [NUM_EP-1:0]     ep_ready;

  // Payload per endpoint, and the expected DATA0/DATA1 state
  logic [7:0]            stash [NUM_EP][DEPTH];
  logic [NUM_EP-1:0]     exp_toggle;
  usb_in_pkg::tx_beat_t  rx_q [$];
  int                    n_checks;
  int                    n_errors;

  tb_clock_gen #(
    .PERIOD_NS   (8),
    .RESET_CYCLES(2)
  ) u_clock_gen (
    .clock_o(clock),
    .reset_o(reset)
  );

  usb_bulk_in #(
    .NUM_EP(NUM_EP),
    .DEPTH (DEPTH)
  ) usb_bulk_in_i (
    .clock        (clock),
    .reset_i      (reset),
    .conf_i       (conf),
    .src_valid_i  (src_valid),
    .src_beat_i   (src_beat),
    .token_valid_i(token_valid),
    .token_i      (token),
    .hs_i         (hs),
    .usb_ready_i  (usb_ready),
    .src_ready_o  (src_ready),
    .usb_valid_o  (usb_valid),
    .usb_beat_o   (usb_beat),
    .nak_o        (nak),
    .busy_o       (busy),
    .ep_ready_o   (ep_ready)
  );

  task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED at %0t ns: %s expected %b got %b", $time, what, exp, act);
    end
  endtask

  task automatic check_beat(input string what, input usb_in_pkg::tx_beat_t exp,
                            input usb_in_pkg::tx_beat_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED at %0t ns: %s expected last=%b data1=%b data=%h got last=%b data1=%b data=%h",
               $time, what, exp.tlast, exp.data1, exp.tdata, act.tlast, act.data1, act.tdata);
    end
  endtask

  task automatic check_len(input string what, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_errors++;
      $display("FAILED at %0t ns: %s expected %0d got %0d", $time, what, exp, act);
    end
  endtask

  task automatic finish_test(input string name, input int start_errs);
    $display("test %s finished, %0d errors", name, n_errors - start_errs);
  endtask

  // Random bytes for one endpoint, from offset 0
  task automatic fill_payload(input int ep, input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = $urandom();
      stash[ep][i] = r[7:0];
    end
  endtask

  // Always ready, or a coin flip per cycle
  function automatic logic pick_ready(input bit bp);
    logic [31:0] r;
    r = $urandom();
    return bp ? r[0] : 1'b1;
  endfunction

  // Source side, holds each beat until taken
  task automatic write_packet(input int ep, input int first, input int n, input bit last);
    for (int i = 0; i < n; i++) begin
      @(negedge clock);
      src_valid      = 1'b1;
      src_beat.tdest = ep[usb_in_pkg::EP_BITS-1:0];
      src_beat.tdata = stash[ep][first + i];
      src_beat.tlast = last && (i == n - 1);
      #1;
      while (!src_ready) begin
        @(negedge clock);
        #1;
      end
      @(posedge clock);
    end
    @(negedge clock);
    src_valid = 1'b0;
    src_beat  = '0;
  endtask

  task automatic wait_ready(input int ep);
    int n;
    n = 0;
    while (!ep_ready[ep] && n < 16) begin
      @(negedge clock);
      n++;
    end
    n_checks++;
    if (!ep_ready[ep]) begin
      n_errors++;
      $display("Endpoint %0d never reported a closed packet (at %0t ns)", ep, $time);
    end
  endtask

  // Token for an empty endpoint, NAK exactly one cycle after the token edge
  task automatic expect_nak(input int ep);
    @(negedge clock);
    token_valid = 1'b1;
    token.ep    = ep[usb_in_pkg::EP_BITS-1:0];
    @(negedge clock);
    token_valid = 1'b0;
    check_bit("nak_o", 1'b0, nak);
    check_bit("busy_o", 1'b0, busy);
    @(negedge clock);
    check_bit("nak_o", 1'b1, nak);
    check_bit("busy_o", 1'b0, busy);
    @(negedge clock);
    check_bit("nak_o", 1'b0, nak);
    check_bit("busy_o", 1'b0, busy);
  endtask

  // Token plus collection of the streamed bytes into rx_q
  task automatic read_packet(input int ep, input bit bp);
    usb_in_pkg::tx_beat_t beat;
    bit                   done;
    rx_q.delete();
    done = 1'b0;
    @(negedge clock);
    token_valid = 1'b1;
    token.ep    = ep[usb_in_pkg::EP_BITS-1:0];
    @(negedge clock);
    token_valid = 1'b0;
    check_bit("busy_o", 1'b0, busy);
    @(negedge clock);
    check_bit("busy_o", 1'b1, busy);
    check_bit("nak_o", 1'b0, nak);
    while (!done) begin
      usb_ready = pick_ready(bp);
      // Registered outputs, taken on the coming rising edge
      if (usb_valid && usb_ready) begin
        beat = usb_beat;
        rx_q.push_back(beat);
        done = beat.tlast;
      end
      @(negedge clock);
    end
    usb_ready = 1'b0;
    // Nothing follows the tlast byte
    check_bit("usb_valid_o", 1'b0, usb_valid);
  endtask

  task automatic send_handshake(input int ep, input bit ack);
    check_bit("busy_o", 1'b1, busy);
    hs.ack      = ack;
    hs.timedout = !ack;
    @(negedge clock);
    hs = '0;
    check_bit("busy_o", 1'b0, busy);
    // ACK moves the endpoint to the other PID
    if (ack) begin
      exp_toggle[ep] = !exp_toggle[ep];
    end
    repeat (2) @(negedge clock);
  endtask

  task automatic expect_packet(input int ep, input int first, input int n);
    usb_in_pkg::tx_beat_t exp;
    check_len($sformatf("packet length on endpoint %0d", ep), n, rx_q.size());
    for (int i = 0; i < n && i < rx_q.size(); i++) begin
      exp.tlast = (i == n - 1);
      exp.data1 = exp_toggle[ep];
      exp.tdata = stash[ep][first + i];
      check_beat($sformatf("usb_beat_o byte %0d of ep %0d", i, ep), exp, rx_q[i]);
    end
  endtask

  // set_conf or clr_conf, both empty the rings and zero the toggles
  task automatic pulse_conf(input bit set_not_clr);
    @(negedge clock);
    conf.set_conf = set_not_clr;
    conf.clr_conf = !set_not_clr;
    @(negedge clock);
    conf.set_conf = 1'b0;
    conf.clr_conf = 1'b0;
    repeat (3) @(negedge clock);
    exp_toggle = '0;
  endtask

  task automatic idle_after_reset();
    int start;
    start = n_errors;
    check_bit("src_ready_o", 1'b0, src_ready);
    check_bit("usb_valid_o", 1'b0, usb_valid);
    check_bit("nak_o", 1'b0, nak);
    check_bit("busy_o", 1'b0, busy);
    for (int ep = 0; ep < NUM_EP; ep++) begin
      check_bit($sformatf("ep_ready_o[%0d]", ep), 1'b0, ep_ready[ep]);
    end
    pulse_conf(1'b1);
    for (int ep = 0; ep < NUM_EP; ep++) begin
      expect_nak(ep);
    end
    finish_test("idle_after_reset", start);
  endtask

  task automatic single_packet();
    int start;
    start = n_errors;
    fill_payload(1, 5);
    write_packet(1, 0, 5, 1'b1);
    // Ready one cycle after the closing beat
    check_bit("ep_ready_o[1]", 1'b0, ep_ready[1]);
    @(negedge clock);
    check_bit("ep_ready_o[1]", 1'b1, ep_ready[1]);
    read_packet(1, 1'b0);
    expect_packet(1, 0, 5);
    send_handshake(1, 1'b1);
    expect_nak(1);
    fill_payload(1, 5);
    write_packet(1, 0, 5, 1'b1);
    wait_ready(1);
    read_packet(1, 1'b0);
    expect_packet(1, 0, 5);
    send_handshake(1, 1'b1);
    finish_test("single_packet", start);
  endtask

  task automatic max_size_split();
    int start;
    start = n_errors;
    @(negedge clock);
    conf.max_size = 8;
    fill_payload(0, 20);
    write_packet(0, 0, 20, 1'b1);
    // 8 + 8 + 4, toggles follow the model
    for (int k = 0; k < 3; k++) begin
      wait_ready(0);
      read_packet(0, 1'b0);
      expect_packet(0, k * 8, (k == 2) ? 4 : 8);
      send_handshake(0, 1'b1);
    end
    expect_nak(0);
    conf.max_size = 64;
    finish_test("max_size_split", start);
  endtask

  task automatic replay_on_timeout();
    int start;
    start = n_errors;
    fill_payload(2, 7);
    write_packet(2, 0, 7, 1'b1);
    wait_ready(2);
    read_packet(2, 1'b0);
    expect_packet(2, 0, 7);
    send_handshake(2, 1'b0);
    wait_ready(2);
    read_packet(2, 1'b0);
    expect_packet(2, 0, 7);
    send_handshake(2, 1'b1);
    expect_nak(2);
    finish_test("replay_on_timeout", start);
  endtask

  task automatic routing_backpressure();
    int start;
    start = n_errors;
    fill_payload(0, 9);
    fill_payload(2, 12);
    fill_payload(3, 6);
    write_packet(0, 0, 9, 1'b1);
    write_packet(2, 0, 12, 1'b1);
    write_packet(3, 0, 6, 1'b1);
    wait_ready(0);
    wait_ready(2);
    wait_ready(3);
    read_packet(3, 1'b1);
    expect_packet(3, 0, 6);
    send_handshake(3, 1'b1);
    read_packet(0, 1'b1);
    expect_packet(0, 0, 9);
    send_handshake(0, 1'b1);
    read_packet(2, 1'b1);
    expect_packet(2, 0, 12);
    send_handshake(2, 1'b1);
    finish_test("routing_backpressure", start);
  endtask

  task automatic clear_configuration();
    int start;
    start = n_errors;
    // One ACKed packet puts endpoint 1 on DATA1
    fill_payload(1, 4);
    write_packet(1, 0, 4, 1'b1);
    wait_ready(1);
    read_packet(1, 1'b0);
    expect_packet(1, 0, 4);
    send_handshake(1, 1'b1);
    // Packets left behind in two rings
    fill_payload(1, 6);
    write_packet(1, 0, 6, 1'b1);
    fill_payload(2, 5);
    write_packet(2, 0, 5, 1'b1);
    wait_ready(1);
    wait_ready(2);
    pulse_conf(1'b0);
    pulse_conf(1'b1);
    for (int ep = 0; ep < NUM_EP; ep++) begin
      check_bit($sformatf("ep_ready_o[%0d]", ep), 1'b0, ep_ready[ep]);
      expect_nak(ep);
    end
    fill_payload(1, 3);
    write_packet(1, 0, 3, 1'b1);
    wait_ready(1);
    read_packet(1, 1'b0);
    expect_packet(1, 0, 3);
    send_handshake(1, 1'b1);
    finish_test("clear_configuration", start);
  endtask

  // Hang guard sized from the byte count of all tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    $timeformat(-9, 0, "", 0);
    void'($urandom(SEED));
    conf          = '0;
    conf.max_size = 64;
    src_valid     = 1'b0;
    src_beat      = '0;
    token_valid   = 1'b0;
    token         = '0;
    hs            = '0;
    usb_ready     = 1'b0;
    exp_toggle    = '0;
    n_checks      = 0;
    n_errors      = 0;
    @(negedge clock);
    while (reset) begin
      @(negedge clock);
    end
    idle_after_reset();
    single_packet();
    max_size_split();
    replay_on_timeout();
    routing_backpressure();
    clear_configuration();
    $display("checks passed: %0d, failed: %0d", n_checks - n_errors, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- usb_bulk_in.f
hw/usb_in_pkg.sv
hw/ep_dispatch.sv
hw/ep_in_buffer.sv
hw/ep_tx_arbiter.sv
hw/usb_bulk_in.sv
tests/tb_clock_gen.sv
tests/tb_usb_bulk_in.sv

//--- Makefile
# Verilator build and run of the bulk IN testbench

TOP  := tb_usb_bulk_in
BIN  := obj_dir/V$(TOP)
SRCS := $(shell cat usb_bulk_in.f)

.PHONY: all run clean

all: run

# Binary is rebuilt only when a source or the file list changes
$(BIN): usb_bulk_in.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f usb_bulk_in.f -o V$(TOP)

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
